// ==== flist.f ====
common/core_pkg.sv
fetch/pc_counter.sv
fetch/fetch_ctrl.sv
verilog/regfile.sv
verilog/scoreboard.sv
verilog/decode_stage.sv
verilog/alu_stage.sv
verilog/core_top.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_top
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --timing -Wall
SIM_FLAGS  ?= --timing -Wno-fatal
PASS_MSG   ?= Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "sim: pass message found in $(LOG)"; \
	else \
	  echo "sim: pass message missing from $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_top.sv ====
module tb_top;

  localparam int prog_depth   = 256;    // Program words, index by addr[7:0]
  localparam int body_len     = 48;     // Instructions after register init
  localparam int done_timeout = 4000;   // Cycles allowed for all writebacks
  localparam int quiet_cycles = 50;     // Window for stray writebacks
  localparam int seed         = 27407;

  logic        clk;
  logic        rst;
  logic        imem_valid;
  logic [15:0] imem_addr;
  logic        imem_ready;
  logic [31:0] imem_inst;
  logic        wb_valid;
  logic [4:0]  wb_rd_num;
  logic [31:0] wb_rd_data;
  logic        load;                   // Checker rebuilds its model
  logic [31:0] prog [prog_depth];
  int          exp_total;
  int          got_total;
  int          err_total;
  int          lat_max;                // Cache delay, bound or fixed
  logic        lat_random;             // Draw a new delay per request
  int          wait_cnt;               // Cycles left before ready, -1 idle
  int          tests_run;
  int          tests_failed;

  always #10 clk = ~clk;

  core_top dut0 (
    .clkrst_core_clk(clk), .rst(rst), .imem_valid(imem_valid), .imem_addr(imem_addr),
    .imem_ready(imem_ready), .imem_inst(imem_inst), .wb_valid(wb_valid),
    .wb_rd_num(wb_rd_num), .wb_rd_data(wb_rd_data));

  tb_checker #(.prog_depth(prog_depth)) chk (
    .clk(clk), .rst(rst), .load(load), .prog(prog), .imem_valid(imem_valid),
    .imem_ready(imem_ready), .imem_addr(imem_addr),
    .wb_valid(wb_valid), .wb_rd_num(wb_rd_num), .wb_rd_data(wb_rd_data),
    .exp_total(exp_total), .got_total(got_total), .err_total(err_total));

  function automatic logic [31:0] encode(int op, int rd, int rs, int rt, int imm);
    return {op[3:0], rd[4:0], rs[4:0], rt[4:0], imm[12:0]};
  endfunction

  // Init r1..r31, random body, optional forward branches, self-loop at the end
  task automatic gen_program(input int chain, input int br_pct, input int zero_pct);
    int i;
    int pos;
    int last;
    int k;
    int op;
    int rd;
    int rs;
    int rt;
    int last_rd;
    for (i = 0; i < prog_depth; i++) prog[i] = encode(9, 1 + i % 31, 0, 0, i);  // Wrong path
    for (i = 1; i < 32; i++) prog[i-1] = encode(9, i, 0, 0, $urandom % 8192);
    pos     = 31;
    last    = 31 + body_len;
    last_rd = 1;
    while (pos < last) begin
      if ($urandom % 100 < br_pct && pos + 2 <= last) begin
        k = 2 + $urandom % 3;                          // Skip 1 to 3 words
        if (pos + k > last) k = last - pos;
        prog[pos] = encode(10, 0, 0, 0, k);
      end else begin
        op = 1 + $urandom % 9;                         // ADD..MOVI
        if ($urandom % 12 == 0) op = 11 + $urandom % 5;  // Unassigned code
        rd = 1 + $urandom % 31;
        rs = $urandom % 32;
        rt = $urandom % 32;
        if ($urandom % 100 < zero_pct) rd = 0;
        if ($urandom % 100 < zero_pct) rs = 0;
        if (chain != 0) begin
          rs = last_rd;                                // Read previous result
          if ($urandom % 2 == 1) rt = last_rd;
        end
        prog[pos] = encode(op, rd, rs, rt, $urandom % 8192);
        if (rd != 0) last_rd = rd;
      end
      pos++;
    end
    prog[last] = encode(10, 0, 0, 0, 0);
  endtask

  // Instruction cache, one ready pulse per request after the chosen delay
  always @(posedge clk) begin
    if (rst) begin
      imem_ready <= 1'b0;
      wait_cnt = -1;
    end else if (imem_ready) begin
      imem_ready <= 1'b0;                              // Word taken this edge
    end else if (imem_valid) begin
      if (wait_cnt < 0) wait_cnt = lat_random ? int'($urandom % (lat_max + 1)) : lat_max;
      if (wait_cnt == 0) begin
        imem_ready <= 1'b1;
        imem_inst  <= prog[imem_addr[7:0]];
        wait_cnt = -1;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  end

  task automatic run_test(input string name, input int chain, input int br_pct,
                          input int zero_pct, input int lat, input logic lat_rand);
    int   errs_before;
    int   cyc;
    logic failed;
    errs_before = err_total;
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    gen_program(chain, br_pct, zero_pct);
    lat_max    = lat;
    lat_random = lat_rand;
    load <= 1'b1;
    @(posedge clk);
    load <= 1'b0;
    for (cyc = 2; cyc < 8; cyc++) @(posedge clk);    // 8 cycles of reset in all
    rst <= 1'b0;
    for (cyc = 0; cyc < done_timeout && got_total < exp_total; cyc++) @(posedge clk);
    failed = (got_total < exp_total);
    if (failed) begin
      $display("Timeout in %s: only %0d of %0d writebacks after %0d cycles",
               name, got_total, exp_total, done_timeout);
    end
    for (cyc = 0; cyc < quiet_cycles; cyc++) @(posedge clk);  // Catch extras
    if (err_total != errs_before) failed = 1'b1;
    tests_run++;
    if (failed) tests_failed++;
    $display("test %s %s, %0d of %0d writebacks, %0d errors", name,
             failed ? "failed" : "ok", got_total, exp_total, err_total - errs_before);
  endtask

  initial begin
    void'($urandom(seed));
    clk          = 1'b0;
    rst          = 1'b1;
    load         = 1'b0;
    imem_ready   = 1'b0;
    imem_inst    = '0;
    lat_max      = 0;
    lat_random   = 1'b0;
    wait_cnt     = -1;
    tests_run    = 0;
    tests_failed = 0;
    run_test("alu_random", 0, 0, 0, 0, 1'b0);
    run_test("dep_chain", 1, 0, 0, 1, 1'b0);
    run_test("fwd_branch", 0, 20, 0, 0, 1'b0);
    run_test("rand_latency", 1, 20, 0, 5, 1'b1);
    run_test("reg_zero", 0, 10, 30, 2, 1'b1);
    $display("Summary: %0d tests, %0d ok, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, err_total);
    if (tests_failed == 0 && err_total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== dv/tb_checker.sv ====
module tb_checker #(
  parameter int prog_depth = 256
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        load,                // Rebuild expected writebacks from prog
  input  logic [31:0] prog [prog_depth],
  input  logic        imem_valid,
  input  logic        imem_ready,
  input  logic [15:0] imem_addr,
  input  logic        wb_valid,
  input  logic [4:0]  wb_rd_num,
  input  logic [31:0] wb_rd_data,
  output int          exp_total,           // Writebacks the model predicts
  output int          got_total,           // Writebacks matched so far
  output int          err_total
);

  localparam int exp_depth  = 1024;
  localparam int step_limit = 2000;        // Model steps before giving up

  logic [4:0]  exp_num  [exp_depth];
  logic [31:0] exp_data [exp_depth];
  logic        rst_q;                      // Reset seen on the previous edge too
  logic        req_open;                   // Fetch request waiting for ready
  logic [15:0] req_addr;                   // Its address

  initial begin
    exp_total = 0;
    got_total = 0;
    err_total = 0;
    rst_q     = 1'b0;
    req_open  = 1'b0;
    req_addr  = '0;
  end

  // Architectural model, walks the program in order until the self-loop
  task automatic build_model(output int n, inout int errs);
    logic [31:0] regs [32];
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic [15:0] pc;
    logic [3:0]  op;
    logic [4:0]  rd;
    logic        wr;
    logic        done;
    int          steps;
    int          r;
    for (r = 0; r < 32; r++) regs[r] = '0;
    pc    = '0;
    n     = 0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < step_limit) begin
      inst = prog[pc[7:0]];
      op   = inst[31:28];
      rd   = inst[27:23];
      a    = regs[inst[22:18]];                  // regs[0] never written
      b    = regs[inst[17:13]];
      imm  = {{19{inst[12]}}, inst[12:0]};
      wr   = 1'b1;
      res  = '0;
      case (op)
        4'd1:    res = a + b;                    // ADD
        4'd2:    res = a - b;                    // SUB
        4'd3:    res = a & b;
        4'd4:    res = a | b;
        4'd5:    res = a ^ b;
        4'd6:    res = a << b[4:0];              // SHL
        4'd7:    res = a >> b[4:0];              // SHR, zero fill
        4'd8:    res = a + imm;                  // ADDI
        4'd9:    res = imm;                      // MOVI
        default: wr = 1'b0;                      // NOP, BR, codes 11..15
      endcase
      if (op == 4'd10) begin
        if (inst[12:0] == '0) done = 1'b1;       // Final self-loop
        else pc = pc + imm[15:0];
      end else begin
        if (wr && rd != '0 && n < exp_depth) begin
          regs[rd]    = res;
          exp_num[n]  = rd;
          exp_data[n] = res;
          n++;
        end
        pc = pc + 16'd1;
      end
      steps++;
    end
    if (!done) begin
      $display("Model did not reach the final self-loop within %0d steps", step_limit);
      errs++;
    end
  endtask

  always @(posedge clk) begin : watch
    int errs_now;
    int n;
    errs_now = 0;
    n        = 0;
    rst_q   <= rst;
    if (load) begin
      build_model(n, errs_now);
      exp_total <= n;
      got_total <= 0;
    end else if (rst) begin
      if (rst_q && wb_valid !== 1'b0) begin
        $display("Writeback strobe was not low during reset at time %0t", $time);
        errs_now++;
      end
      if (rst_q && imem_valid !== 1'b0) begin
        $display("Fetch request was not low during reset at time %0t", $time);
        errs_now++;
      end
    end else if (wb_valid) begin
      if (got_total >= exp_total) begin
        $display("Extra writeback at time %0t to r%0d with %h", $time, wb_rd_num, wb_rd_data);
        errs_now++;
      end else begin
        if (wb_rd_num !== exp_num[got_total]) begin
          $display("FAIL time=%0t signal=wb_rd_num expected=%0d actual=%0d",
                   $time, exp_num[got_total], wb_rd_num);
          errs_now++;
        end
        if (wb_rd_data !== exp_data[got_total]) begin
          $display("FAIL time=%0t signal=wb_rd_data expected=%h actual=%h",
                   $time, exp_data[got_total], wb_rd_data);
          errs_now++;
        end
        got_total <= got_total + 1;            // Next expected entry
      end
    end
    if (rst) begin
      req_open <= 1'b0;
    end else begin
      if (req_open && (imem_valid !== 1'b1 || imem_addr !== req_addr)) begin
        $display("Fetch request to %h was dropped or moved before ready at time %0t",
                 req_addr, $time);
        errs_now++;
      end
      req_open <= imem_valid & ~imem_ready;    // Cache has not answered yet
      req_addr <= imem_addr;
    end
    err_total <= err_total + errs_now;
  end

endmodule

// ==== verilog/core_top.sv ====
module core_top (
  input  logic                          clkrst_core_clk,
  input  logic                          rst,
  output logic                          imem_valid,
  output logic [core_pkg::pc_w-1:0]     imem_addr,
  input  logic                          imem_ready,
  input  logic [core_pkg::xlen-1:0]     imem_inst,
  output logic                          wb_valid,
  output logic [core_pkg::reg_num_w-1:0] wb_rd_num,
  output logic [core_pkg::xlen-1:0]     wb_rd_data
);

  logic [core_pkg::pc_w-1:0]      pc;            // Next fetch address
  logic                           fetch_accept;  // I$ word taken
  logic                           f_valid;       // Fetch entry held
  logic [core_pkg::xlen-1:0]      f_inst;
  logic [core_pkg::pc_w-1:0]      f_pc;
  logic                           d_take;        // Decode consumes fetch entry
  logic [core_pkg::reg_num_w-1:0] rf_rs_num;
  logic [core_pkg::reg_num_w-1:0] rf_rt_num;
  logic [core_pkg::xlen-1:0]      rf_rs_data;
  logic [core_pkg::xlen-1:0]      rf_rt_data;
  logic [core_pkg::num_regs-1:0]  sb_busy;       // Pending writes
  logic                           sb_set;
  logic [core_pkg::reg_num_w-1:0] sb_set_num;
  logic                           redirect;      // Taken branch in execute
  logic [core_pkg::pc_w-1:0]      redirect_pc;
  logic                           x_valid;       // Execute stage inputs
  core_pkg::opcode_e              x_op;
  logic [core_pkg::reg_num_w-1:0] x_rd_num;
  logic                           x_rd_we;
  logic [core_pkg::xlen-1:0]      x_rs_data;
  logic [core_pkg::xlen-1:0]      x_rt_data;
  logic [core_pkg::xlen-1:0]      x_imm;
  logic [core_pkg::pc_w-1:0]      x_pc;

  fetch_ctrl f (
    .clkrst_core_clk(clkrst_core_clk), .rst(rst), .pc(pc), .fetch_accept(fetch_accept),
    .imem_valid(imem_valid), .imem_addr(imem_addr), .imem_ready(imem_ready),
    .imem_inst(imem_inst), .redirect(redirect), .d_take(d_take),
    .f_valid(f_valid), .f_inst(f_inst), .f_pc(f_pc));

  pc_counter pc0 (
    .clkrst_core_clk(clkrst_core_clk), .rst(rst), .fetch_accept(fetch_accept),
    .redirect(redirect), .redirect_pc(redirect_pc), .pc(pc));

  decode_stage d (
    .clkrst_core_clk(clkrst_core_clk), .rst(rst), .f_valid(f_valid), .f_inst(f_inst),
    .f_pc(f_pc), .d_take(d_take), .rf_rs_num(rf_rs_num), .rf_rt_num(rf_rt_num),
    .rf_rs_data(rf_rs_data), .rf_rt_data(rf_rt_data), .sb_busy(sb_busy),
    .sb_set(sb_set), .sb_set_num(sb_set_num), .redirect(redirect),
    .x_valid(x_valid), .x_op(x_op), .x_rd_num(x_rd_num), .x_rd_we(x_rd_we),
    .x_rs_data(x_rs_data), .x_rt_data(x_rt_data), .x_imm(x_imm), .x_pc(x_pc));

  scoreboard sb (
    .clkrst_core_clk(clkrst_core_clk), .rst(rst), .sb_set(sb_set), .sb_set_num(sb_set_num),
    .wb_valid(wb_valid), .wb_rd_num(wb_rd_num), .sb_busy(sb_busy));

  regfile regs (
    .clkrst_core_clk(clkrst_core_clk), .rs_num(rf_rs_num), .rt_num(rf_rt_num),
    .rs_data(rf_rs_data), .rt_data(rf_rt_data),
    .we(wb_valid), .wr_num(wb_rd_num), .wr_data(wb_rd_data));  // Writeback port

  alu_stage alu (
    .clkrst_core_clk(clkrst_core_clk), .rst(rst), .x_valid(x_valid), .x_op(x_op),
    .x_rd_num(x_rd_num), .x_rd_we(x_rd_we), .x_rs_data(x_rs_data),
    .x_rt_data(x_rt_data), .x_imm(x_imm), .x_pc(x_pc),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .wb_valid(wb_valid), .wb_rd_num(wb_rd_num), .wb_rd_data(wb_rd_data));

endmodule

// ==== verilog/alu_stage.sv ====
module alu_stage (
  input  logic                           clkrst_core_clk,
  input  logic                           rst,
  input  logic                           x_valid,
  input  core_pkg::opcode_e              x_op,
  input  logic [core_pkg::reg_num_w-1:0] x_rd_num,
  input  logic                           x_rd_we,
  input  logic [core_pkg::xlen-1:0]      x_rs_data,
  input  logic [core_pkg::xlen-1:0]      x_rt_data,
  input  logic [core_pkg::xlen-1:0]      x_imm,
  input  logic [core_pkg::pc_w-1:0]      x_pc,
  output logic                           redirect,
  output logic [core_pkg::pc_w-1:0]      redirect_pc,
  output logic                           wb_valid,
  output logic [core_pkg::reg_num_w-1:0] wb_rd_num,
  output logic [core_pkg::xlen-1:0]      wb_rd_data
);

  logic [core_pkg::xlen-1:0]    result;
  logic [core_pkg::shamt_w-1:0] shamt;  // Low bits of rt

  assign shamt = x_rt_data[core_pkg::shamt_w-1:0];

  always_comb begin
    case (x_op)
      core_pkg::op_add:  result = x_rs_data + x_rt_data;
      core_pkg::op_sub:  result = x_rs_data - x_rt_data;
      core_pkg::op_and:  result = x_rs_data & x_rt_data;
      core_pkg::op_or:   result = x_rs_data | x_rt_data;
      core_pkg::op_xor:  result = x_rs_data ^ x_rt_data;
      core_pkg::op_shl:  result = x_rs_data << shamt;
      core_pkg::op_shr:  result = x_rs_data >> shamt;  // Zero fill
      core_pkg::op_addi: result = x_rs_data + x_imm;
      core_pkg::op_movi: result = x_imm;
      default:           result = '0;                  // No write anyway
    endcase
  end

  // Branch resolves here and flushes fetch and decode
  assign redirect    = x_valid & (x_op == core_pkg::op_br);
  assign redirect_pc = x_pc + x_imm[core_pkg::pc_w-1:0];  // Wraps in word space

  always_ff @(posedge clkrst_core_clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= x_valid & x_rd_we;  // Only writing instructions retire on wb
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (x_valid) begin
      wb_rd_num  <= x_rd_num;
      wb_rd_data <= result;
    end
  end

endmodule

// ==== verilog/decode_stage.sv ====
module decode_stage (
  input  logic                           clkrst_core_clk,
  input  logic                           rst,
  input  logic                           f_valid,
  input  logic [core_pkg::xlen-1:0]      f_inst,
  input  logic [core_pkg::pc_w-1:0]      f_pc,
  output logic                           d_take,
  output logic [core_pkg::reg_num_w-1:0] rf_rs_num,
  output logic [core_pkg::reg_num_w-1:0] rf_rt_num,
  input  logic [core_pkg::xlen-1:0]      rf_rs_data,
  input  logic [core_pkg::xlen-1:0]      rf_rt_data,
  input  logic [core_pkg::num_regs-1:0]  sb_busy,
  output logic                           sb_set,
  output logic [core_pkg::reg_num_w-1:0] sb_set_num,
  input  logic                           redirect,
  output logic                           x_valid,
  output core_pkg::opcode_e              x_op,
  output logic [core_pkg::reg_num_w-1:0] x_rd_num,
  output logic                           x_rd_we,
  output logic [core_pkg::xlen-1:0]      x_rs_data,
  output logic [core_pkg::xlen-1:0]      x_rt_data,
  output logic [core_pkg::xlen-1:0]      x_imm,
  output logic [core_pkg::pc_w-1:0]      x_pc
);

  core_pkg::opcode_e              op;
  logic [core_pkg::reg_num_w-1:0] rd_num;
  logic [core_pkg::reg_num_w-1:0] rs_num;
  logic [core_pkg::reg_num_w-1:0] rt_num;
  logic [core_pkg::xlen-1:0]      imm_ext;  // Sign extended immediate
  logic                           rs_used;
  logic                           rt_used;
  logic                           rd_we;
  logic                           stall;    // Scoreboard hazard
  logic                           proceed;  // Instruction moves to execute

  assign op     = core_pkg::opcode_e'(f_inst[core_pkg::opcode_lsb +: core_pkg::opcode_w]);
  assign rd_num = f_inst[core_pkg::rd_lsb +: core_pkg::reg_num_w];
  assign rs_num = f_inst[core_pkg::rs_lsb +: core_pkg::reg_num_w];
  assign rt_num = f_inst[core_pkg::rt_lsb +: core_pkg::reg_num_w];
  assign imm_ext = {{(core_pkg::xlen - core_pkg::imm_w){f_inst[core_pkg::imm_w-1]}},
                    f_inst[core_pkg::imm_w-1:0]};

  // Source usage and write enable per opcode
  always_comb begin
    rs_used = 1'b0;
    rt_used = 1'b0;
    rd_we   = 1'b0;
    case (op)
      core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and, core_pkg::op_or,
      core_pkg::op_xor, core_pkg::op_shl, core_pkg::op_shr: begin
        rs_used = 1'b1;
        rt_used = 1'b1;
        rd_we   = 1'b1;
      end
      core_pkg::op_addi: begin
        rs_used = 1'b1;
        rd_we   = 1'b1;
      end
      core_pkg::op_movi: rd_we = 1'b1;
      default: rd_we = 1'b0;  // NOP, BR, unassigned codes
    endcase
    if (rd_num == '0) begin
      rd_we = 1'b0;  // r0 writes dropped
    end
  end

  assign stall = (rs_used & sb_busy[rs_num]) | (rt_used & sb_busy[rt_num]) |
                 (rd_we & sb_busy[rd_num]);  // WAW too, keeps set and clear apart
  assign proceed = f_valid & ~stall & ~redirect;  // Squash on branch

  assign d_take     = proceed;
  assign rf_rs_num  = rs_num;  // Async read, same cycle
  assign rf_rt_num  = rt_num;
  assign sb_set     = proceed & rd_we;
  assign sb_set_num = rd_num;

  always_ff @(posedge clkrst_core_clk) begin
    if (rst) begin
      x_valid <= 1'b0;
    end else begin
      x_valid <= proceed;  // Bubble on stall or redirect
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (proceed) begin
      x_op      <= op;
      x_rd_num  <= rd_num;
      x_rd_we   <= rd_we;
      x_rs_data <= rf_rs_data;
      x_rt_data <= rf_rt_data;
      x_imm     <= imm_ext;
      x_pc      <= f_pc;
    end
  end

endmodule

// ==== verilog/scoreboard.sv ====
module scoreboard (
  input  logic                           clkrst_core_clk,
  input  logic                           rst,
  input  logic                           sb_set,
  input  logic [core_pkg::reg_num_w-1:0] sb_set_num,
  input  logic                           wb_valid,
  input  logic [core_pkg::reg_num_w-1:0] wb_rd_num,
  output logic [core_pkg::num_regs-1:0]  sb_busy
);

  logic [core_pkg::num_regs-1:0] set_mask;  // One hot issue
  logic [core_pkg::num_regs-1:0] clr_mask;  // One hot retire

  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    if (sb_set) begin
      set_mask[sb_set_num] = 1'b1;
    end
    if (wb_valid) begin
      clr_mask[wb_rd_num] = 1'b1;
    end
  end

  // Set and clear never hit the same register
  always_ff @(posedge clkrst_core_clk) begin
    if (rst) begin
      sb_busy <= '0;  // Nothing pending
    end else begin
      sb_busy <= (sb_busy | set_mask) & ~clr_mask;
    end
  end

endmodule

// ==== verilog/regfile.sv ====
module regfile (
  input  logic                           clkrst_core_clk,
  input  logic [core_pkg::reg_num_w-1:0] rs_num,
  input  logic [core_pkg::reg_num_w-1:0] rt_num,
  output logic [core_pkg::xlen-1:0]      rs_data,
  output logic [core_pkg::xlen-1:0]      rt_data,
  input  logic                           we,
  input  logic [core_pkg::reg_num_w-1:0] wr_num,
  input  logic [core_pkg::xlen-1:0]      wr_data
);

  logic [core_pkg::xlen-1:0] regs [core_pkg::num_regs];

  // r0 hardwired to zero on the read side
  assign rs_data = (rs_num == '0) ? '0 : regs[rs_num];
  assign rt_data = (rt_num == '0) ? '0 : regs[rt_num];

  always_ff @(posedge clkrst_core_clk) begin
    if (we && (wr_num != '0)) begin
      regs[wr_num] <= wr_data;  // Visible to decode next cycle
    end
  end

endmodule

// ==== fetch/fetch_ctrl.sv ====
module fetch_ctrl (
  input  logic                      clkrst_core_clk,
  input  logic                      rst,
  input  logic [core_pkg::pc_w-1:0] pc,
  output logic                      fetch_accept,
  output logic                      imem_valid,
  output logic [core_pkg::pc_w-1:0] imem_addr,
  input  logic                      imem_ready,
  input  logic [core_pkg::xlen-1:0] imem_inst,
  input  logic                      redirect,
  input  logic                      d_take,
  output logic                      f_valid,
  output logic [core_pkg::xlen-1:0] f_inst,
  output logic [core_pkg::pc_w-1:0] f_pc
);

  core_pkg::fetch_state_e state;
  logic                   ret;    // I$ returns a word this cycle
  logic                   issue;  // Start a new request next cycle

  assign ret          = imem_valid & imem_ready;
  assign issue        = (state == core_pkg::fs_req) & ~imem_valid & ~redirect;  // Wait for pc reload
  assign fetch_accept = ret & (state == core_pkg::fs_req) & ~redirect;  // Squashed word not taken
  assign f_valid      = (state == core_pkg::fs_hold);

  always_ff @(posedge clkrst_core_clk) begin
    if (rst) begin
      state      <= core_pkg::fs_req;
      imem_valid <= 1'b0;
    end else begin
      case (state)
        core_pkg::fs_req: begin
          if (ret) begin
            imem_valid <= 1'b0;           // Request done
            if (!redirect) begin
              state <= core_pkg::fs_hold;
            end
          end else if (imem_valid && redirect) begin
            state <= core_pkg::fs_drop;   // Keep strobe up, discard the answer
          end else if (issue) begin
            imem_valid <= 1'b1;
          end
        end
        core_pkg::fs_hold: begin
          if (redirect || d_take) begin
            state <= core_pkg::fs_req;    // Flush or consumed
          end
        end
        core_pkg::fs_drop: begin
          if (ret) begin
            imem_valid <= 1'b0;
            state      <= core_pkg::fs_req;  // Refetch at new pc
          end
        end
        default: state <= core_pkg::fs_req;
      endcase
    end
  end

  // Address stays stable while the strobe is up
  always_ff @(posedge clkrst_core_clk) begin
    if (issue) begin
      imem_addr <= pc;
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (fetch_accept) begin
      f_inst <= imem_inst;
      f_pc   <= imem_addr;  // Own word address for BR
    end
  end

endmodule

// ==== fetch/pc_counter.sv ====
module pc_counter (
  input  logic                      clkrst_core_clk,
  input  logic                      rst,
  input  logic                      fetch_accept,
  input  logic                      redirect,
  input  logic [core_pkg::pc_w-1:0] redirect_pc,
  output logic [core_pkg::pc_w-1:0] pc
);

  logic [core_pkg::pc_w-1:0] pc_inc;  // Sequential next word

  assign pc_inc = pc + 1'b1;  // One word per instruction

  always_ff @(posedge clkrst_core_clk) begin
    if (rst) begin
      pc <= '0;                // Boot address
    end else if (redirect) begin
      pc <= redirect_pc;       // Branch wins over stepping
    end else if (fetch_accept) begin
      pc <= pc_inc;
    end
  end

endmodule

// ==== common/core_pkg.sv ====
package core_pkg;

  localparam int xlen      = 32;  // Data path width
  localparam int reg_num_w = 5;   // Register index width
  localparam int num_regs  = 32;  // Architectural registers
  localparam int pc_w      = 16;  // Word address width
  localparam int imm_w     = 13;  // Immediate field width
  localparam int opcode_w  = 4;   // Opcode field width
  localparam int shamt_w   = 5;   // Shift amount bits taken from rt

  // Instruction field positions
  localparam int opcode_lsb = 28;  // Bits 31:28
  localparam int rd_lsb     = 23;  // Bits 27:23
  localparam int rs_lsb     = 18;  // Bits 22:18
  localparam int rt_lsb     = 13;  // Bits 17:13

  // Codes 11 to 15 are unassigned and decode as NOP
  typedef enum logic [opcode_w-1:0] {
    op_nop  = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_and  = 4'd3,
    op_or   = 4'd4,
    op_xor  = 4'd5,
    op_shl  = 4'd6,   // Logical left
    op_shr  = 4'd7,   // Logical right
    op_addi = 4'd8,
    op_movi = 4'd9,
    op_br   = 4'd10   // PC relative, no writeback
  } opcode_e;

  typedef enum logic [1:0] {
    fs_req  = 2'd0,   // Request to I$ at pc
    fs_hold = 2'd1,   // Instruction held for decode
    fs_drop = 2'd2    // Stale request in flight
  } fetch_state_e;

endpackage
